// ==== verilog.f ====
rtl/rename_pkg.sv
rtl/retire_if.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/rename_unit.sv
sim/tb_rename_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_rename_unit \
    -f verilog.f -o tb_rename_unit

output=$(./obj_dir/tb_rename_unit 2>&1 || true)
echo "$output"

if grep -qF 'All tests passed!' <<< "$output"; then
    exit 0
fi
exit 1

// ==== sim/rename_trace.txt ====
# rv src1 src2 dest cdb_v cdb_preg ret_en ret_arch ret_old restore arch_query
# exp: src1 src2 old_dest arch_map as {reg,ready}, new_preg, stall, mask (src1..stall)
0 05 00 00 0 00 0 00 00 0 03 0b 01 01 07 20 0 3f
0 1f 01 00 0 00 0 00 00 0 1f 3f 03 01 3f 20 0 3f
1 01 02 01 0 00 0 00 00 0 01 03 05 01 03 20 0 3f
1 01 02 02 0 00 0 00 00 0 01 40 05 03 03 21 0 3f
1 02 00 00 0 00 0 00 00 0 01 42 01 05 03 22 0 3f
0 00 01 00 0 00 0 00 00 0 01 01 40 01 03 22 0 3f
0 01 02 00 1 20 0 00 00 0 01 41 42 01 03 22 0 3f
1 01 02 02 0 00 0 00 00 0 01 41 42 01 03 22 0 3f
0 01 02 00 1 21 0 00 00 0 01 41 44 43 03 23 0 3f
0 01 02 00 0 00 1 01 01 0 01 41 44 01 03 23 0 3f
0 01 02 00 0 00 0 00 00 0 01 41 44 01 41 23 0 3f
1 02 03 03 0 00 0 00 00 1 02 44 07 01 05 23 0 3f
0 01 02 00 0 00 0 00 00 0 02 41 05 07 05 21 0 3f
1 03 00 03 0 00 0 00 00 0 03 07 01 01 07 21 0 3f
1 03 00 03 0 00 0 00 00 0 03 42 01 07 07 22 0 3f
1 03 00 03 0 00 0 00 00 0 03 44 01 42 07 23 0 3f
1 03 00 03 0 00 0 00 00 0 03 46 01 44 07 24 0 3f
1 03 00 03 0 00 0 00 00 0 03 48 01 46 07 25 0 3f
1 03 00 03 0 00 0 00 00 0 03 4a 01 48 07 26 0 3f
1 03 00 03 0 00 0 00 00 0 03 4c 01 4a 07 27 0 3f
1 03 00 03 0 00 0 00 00 0 03 4e 01 4c 07 28 0 3f
1 03 00 03 0 00 0 00 00 0 03 50 01 4e 07 29 0 3f
1 03 00 03 0 00 0 00 00 0 03 52 01 50 07 2a 0 3f
1 03 00 03 0 00 0 00 00 0 03 54 01 52 07 2b 0 3f
1 03 00 03 0 00 0 00 00 0 03 56 01 54 07 2c 0 3f
1 03 00 03 0 00 0 00 00 0 03 58 01 56 07 2d 0 3f
1 03 00 03 0 00 0 00 00 0 03 5a 01 58 07 2e 0 3f
1 03 00 03 0 00 0 00 00 0 03 5c 01 5a 07 2f 0 3f
1 03 00 03 0 00 0 00 00 0 03 5e 01 5c 07 30 0 3f
1 03 00 03 0 00 0 00 00 0 03 60 01 5e 07 31 0 3f
1 03 00 03 0 00 0 00 00 0 03 62 01 60 07 32 0 3f
1 03 00 03 0 00 0 00 00 0 03 64 01 62 07 33 0 3f
1 03 00 03 0 00 0 00 00 0 03 66 01 64 07 34 0 3f
1 03 00 03 0 00 0 00 00 0 03 68 01 66 07 35 0 3f
1 03 00 03 0 00 0 00 00 0 03 6a 01 68 07 36 0 3f
1 03 00 03 0 00 0 00 00 0 03 6c 01 6a 07 37 0 3f
1 03 00 03 0 00 0 00 00 0 03 6e 01 6c 07 38 0 3f
1 03 00 03 0 00 0 00 00 0 03 70 01 6e 07 39 0 3f
1 03 00 03 0 00 0 00 00 0 03 72 01 70 07 3a 0 3f
1 03 00 03 0 00 0 00 00 0 03 74 01 72 07 3b 0 3f
1 03 00 03 0 00 0 00 00 0 03 76 01 74 07 3c 0 3f
1 03 00 03 0 00 0 00 00 0 03 78 01 76 07 3d 0 3f
1 03 00 03 0 00 0 00 00 0 03 7a 01 78 07 3e 0 3f
1 03 00 03 0 00 0 00 00 0 03 7c 01 7a 07 3f 0 3f
1 03 00 03 0 00 0 00 00 0 03 7e 01 7c 07 01 0 3f
1 03 00 03 0 00 0 00 00 0 03 02 01 7e 07 00 1 2f
1 03 00 03 0 00 0 00 00 0 03 02 01 02 07 00 1 2f
1 03 00 03 0 00 1 03 03 0 03 02 01 02 07 00 1 2f
1 03 00 03 0 00 0 00 00 0 03 02 01 02 02 03 0 3f
0 03 00 00 0 00 0 00 00 0 03 06 01 02 02 00 0 2f
1 03 05 05 0 00 0 00 00 0 03 06 0b 01 02 00 1 2f

// ==== sim/tb_rename_unit.sv ====
// Trace-driven testbench for the rename unit, run from the project root by the simulation script
`timescale 1ns/1ps

module tb_rename_unit;
    import rename_pkg::*;

    localparam int    CLK_PERIOD   = 40;
    localparam int    RESET_CYCLES = 16;
    localparam int    DRIVE_DELAY  = 2;
    localparam int    SLACK_CYCLES = 20;
    localparam int    MAX_LINES    = 256;
    localparam int    NUM_FIELDS   = 18;
    localparam string TRACE_FILE   = "sim/rename_trace.txt";

    // One cycle of stimulus and the outputs expected in that cycle
    typedef struct {
        logic                  rename_valid;
        logic [ARCH_IDX_W-1:0] src1_arch;
        logic [ARCH_IDX_W-1:0] src2_arch;
        logic [ARCH_IDX_W-1:0] dest_arch;
        logic                  cdb_valid;
        logic [PHYS_IDX_W-1:0] cdb_preg;
        logic                  retire_enable;
        logic [ARCH_IDX_W-1:0] retire_arch_reg;
        logic [PHYS_IDX_W-1:0] retire_old_preg;
        logic                  restore_enable;
        logic [ARCH_IDX_W-1:0] arch_query;
        preg_t                 exp_src1;
        preg_t                 exp_src2;
        preg_t                 exp_old_dest;
        preg_t                 exp_arch_map;
        logic [PHYS_IDX_W-1:0] exp_new_preg;
        logic                  exp_stall;
        logic [5:0]            mask;
    } trace_line_t;

    logic                  clk;
    logic                  reset;
    logic                  rename_valid;
    logic [ARCH_IDX_W-1:0] src1_arch;
    logic [ARCH_IDX_W-1:0] src2_arch;
    logic [ARCH_IDX_W-1:0] dest_arch;
    logic                  cdb_valid;
    logic [PHYS_IDX_W-1:0] cdb_preg;
    logic                  retire_enable;
    logic [ARCH_IDX_W-1:0] retire_arch_reg;
    logic [PHYS_IDX_W-1:0] retire_old_preg;
    logic                  restore_enable;
    logic [ARCH_IDX_W-1:0] arch_query;
    preg_t                 src1_preg;
    preg_t                 src2_preg;
    preg_t                 old_dest_preg;
    preg_t                 arch_map_preg;
    logic [PHYS_IDX_W-1:0] new_preg;
    logic                  stall;

    trace_line_t trace [MAX_LINES];
    int          line_count;
    int          checks_done;
    int          cycle_count;
    int          cycle_limit;

    rename_unit u_rename_unit (
        .clk             (clk),
        .reset           (reset),
        .rename_valid    (rename_valid),
        .src1_arch       (src1_arch),
        .src2_arch       (src2_arch),
        .dest_arch       (dest_arch),
        .cdb_valid       (cdb_valid),
        .cdb_preg        (cdb_preg),
        .retire_enable   (retire_enable),
        .retire_arch_reg (retire_arch_reg),
        .retire_old_preg (retire_old_preg),
        .restore_enable  (restore_enable),
        .arch_query      (arch_query),
        .src1_preg       (src1_preg),
        .src2_preg       (src2_preg),
        .old_dest_preg   (old_dest_preg),
        .arch_map_preg   (arch_map_preg),
        .new_preg        (new_preg),
        .stall           (stall)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Hang guard sized from the trace length
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the trace did not finish", cycle_limit);
            $display("Test failures found");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input int line_no,
                               input logic [31:0] actual, input logic [31:0] expected);
        checks_done = checks_done + 1;
        if (actual !== expected) begin
            $display("CHECK FAILED time=%0t line=%0d %s: got %h, expected %h",
                     $time, line_no, name, actual, expected);
            $display("Test failures found");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          got;
        string       line;
        logic [31:0] f [NUM_FIELDS];
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the trace file %s", TRACE_FILE);
            $display("Test failures found");
            $fatal(1, "no stimulus");
        end
        line_count = 0;
        while (!$feof(fd)) begin
            line = "";
            got = $fgets(line, fd);
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                          f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
            // Blank line
            if (got <= 0) begin
                continue;
            end
            if (got != NUM_FIELDS || line_count == MAX_LINES) begin
                $display("Trace line %0d is malformed or the trace is too long", line_count);
                $display("Test failures found");
                $fatal(1, "bad trace");
            end
            trace[line_count].rename_valid    = f[0][0];
            trace[line_count].src1_arch       = f[1][ARCH_IDX_W-1:0];
            trace[line_count].src2_arch       = f[2][ARCH_IDX_W-1:0];
            trace[line_count].dest_arch       = f[3][ARCH_IDX_W-1:0];
            trace[line_count].cdb_valid       = f[4][0];
            trace[line_count].cdb_preg        = f[5][PHYS_IDX_W-1:0];
            trace[line_count].retire_enable   = f[6][0];
            trace[line_count].retire_arch_reg = f[7][ARCH_IDX_W-1:0];
            trace[line_count].retire_old_preg = f[8][PHYS_IDX_W-1:0];
            trace[line_count].restore_enable  = f[9][0];
            trace[line_count].arch_query      = f[10][ARCH_IDX_W-1:0];
            // Expected tags are packed as register number then ready bit
            trace[line_count].exp_src1        = preg_t'(f[11][PHYS_IDX_W:0]);
            trace[line_count].exp_src2        = preg_t'(f[12][PHYS_IDX_W:0]);
            trace[line_count].exp_old_dest    = preg_t'(f[13][PHYS_IDX_W:0]);
            trace[line_count].exp_arch_map    = preg_t'(f[14][PHYS_IDX_W:0]);
            trace[line_count].exp_new_preg    = f[15][PHYS_IDX_W-1:0];
            trace[line_count].exp_stall       = f[16][0];
            trace[line_count].mask            = f[17][5:0];
            line_count = line_count + 1;
        end
        $fclose(fd);
    endtask

    task automatic drive_inputs(input trace_line_t t);
        rename_valid    = t.rename_valid;
        src1_arch       = t.src1_arch;
        src2_arch       = t.src2_arch;
        dest_arch       = t.dest_arch;
        cdb_valid       = t.cdb_valid;
        cdb_preg        = t.cdb_preg;
        retire_enable   = t.retire_enable;
        retire_arch_reg = t.retire_arch_reg;
        retire_old_preg = t.retire_old_preg;
        restore_enable  = t.restore_enable;
        arch_query      = t.arch_query;
    endtask

    // Mask bits: src1, src2, old_dest, arch_map, new_preg, stall
    task automatic compare_outputs(input trace_line_t t, input int line_no);
        if (t.mask[0]) check_value("src1_preg", line_no, 32'(src1_preg), 32'(t.exp_src1));
        if (t.mask[1]) check_value("src2_preg", line_no, 32'(src2_preg), 32'(t.exp_src2));
        if (t.mask[2]) begin
            check_value("old_dest_preg", line_no, 32'(old_dest_preg), 32'(t.exp_old_dest));
        end
        if (t.mask[3]) begin
            check_value("arch_map_preg", line_no, 32'(arch_map_preg), 32'(t.exp_arch_map));
        end
        if (t.mask[4]) check_value("new_preg", line_no, 32'(new_preg), 32'(t.exp_new_preg));
        if (t.mask[5]) check_value("stall", line_no, 32'(stall), 32'(t.exp_stall));
    endtask

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        rename_valid    = 1'b0;
        src1_arch       = '0;
        src2_arch       = '0;
        dest_arch       = '0;
        cdb_valid       = 1'b0;
        cdb_preg        = '0;
        retire_enable   = 1'b0;
        retire_arch_reg = '0;
        retire_old_preg = '0;
        restore_enable  = 1'b0;
        arch_query      = '0;
        checks_done     = 0;
        cycle_count     = 0;

        load_trace();
        cycle_limit = line_count + RESET_CYCLES + SLACK_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;

        for (int n = 0; n < line_count; n++) begin
            if (n > 0) begin
                @(posedge clk);
                #(DRIVE_DELAY);
            end
            drive_inputs(trace[n]);
            // Sample just ahead of the next rising edge
            #(CLK_PERIOD - 2 * DRIVE_DELAY);
            compare_outputs(trace[n], n);
        end

        if (checks_done > 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("The trace held no checked lines");
            $display("Test failures found");
            $fatal(1, "empty trace");
        end
    end

endmodule

// ==== rtl/rename_unit.sv ====
// Register-rename stage top level joining the map table and the free list behind plain ports
`timescale 1ns/1ps

module rename_unit (
    input  logic                              clk,
    input  logic                              reset,

    // Instruction being renamed
    input  logic                              rename_valid,
    input  logic [rename_pkg::ARCH_IDX_W-1:0] src1_arch,
    input  logic [rename_pkg::ARCH_IDX_W-1:0] src2_arch,
    input  logic [rename_pkg::ARCH_IDX_W-1:0] dest_arch,

    // Completion broadcast
    input  logic                              cdb_valid,
    input  logic [rename_pkg::PHYS_IDX_W-1:0] cdb_preg,

    // From the ROB
    input  logic                              retire_enable,
    input  logic [rename_pkg::ARCH_IDX_W-1:0] retire_arch_reg,
    input  logic [rename_pkg::PHYS_IDX_W-1:0] retire_old_preg,
    input  logic                              restore_enable,

    // Retired map query
    input  logic [rename_pkg::ARCH_IDX_W-1:0] arch_query,

    output rename_pkg::preg_t                 src1_preg,
    output rename_pkg::preg_t                 src2_preg,
    output rename_pkg::preg_t                 old_dest_preg,
    output rename_pkg::preg_t                 arch_map_preg,
    output logic [rename_pkg::PHYS_IDX_W-1:0] new_preg,
    output logic                              stall
);
    import rename_pkg::*;

    logic                  alloc_req;
    logic [PHYS_IDX_W-1:0] alloc_preg;
    logic                  alloc_stall;

    retire_if u_retire_if ();

    assign u_retire_if.retire_enable   = retire_enable;
    assign u_retire_if.retire_arch_reg = retire_arch_reg;
    assign u_retire_if.retire_old_preg = retire_old_preg;
    assign u_retire_if.restore_enable  = restore_enable;

    map_table u_map_table (
        .clk           (clk),
        .reset         (reset),
        .src1_arch     (src1_arch),
        .src2_arch     (src2_arch),
        .src1_preg     (src1_preg),
        .src2_preg     (src2_preg),
        .rename_valid  (rename_valid),
        .dest_arch     (dest_arch),
        .alloc_req     (alloc_req),
        .alloc_preg    (alloc_preg),
        .alloc_stall   (alloc_stall),
        .old_dest_preg (old_dest_preg),
        .cdb_valid     (cdb_valid),
        .cdb_preg      (cdb_preg),
        .retire        (u_retire_if.sink),
        .arch_query    (arch_query),
        .arch_map_preg (arch_map_preg)
    );

    free_list u_free_list (
        .clk         (clk),
        .reset       (reset),
        .alloc_req   (alloc_req),
        .alloc_preg  (alloc_preg),
        .alloc_stall (alloc_stall),
        .retire      (u_retire_if.sink)
    );

    // Head of the free list is the tag a rename would receive
    assign new_preg = alloc_preg;
    assign stall    = alloc_stall;

endmodule

// ==== rtl/free_list.sv ====
// Circular list of free physical registers with speculative and retired heads, used inside the rename unit
`timescale 1ns/1ps

module free_list (
    input  logic                              clk,
    input  logic                              reset,

    // Allocation for a renamed destination
    input  logic                              alloc_req,
    output logic [rename_pkg::PHYS_IDX_W-1:0] alloc_preg,
    output logic                              alloc_stall,

    // Retire returns a register, restore rewinds the head
    retire_if.sink                            retire
);
    import rename_pkg::*;

    typedef logic [$clog2(FREE_DEPTH)-1:0] ptr_t;

    logic [PHYS_IDX_W-1:0] entries [FREE_DEPTH];

    // Next register to hand out
    ptr_t spec_head;
    // Oldest allocation not yet retired
    ptr_t retired_head;
    // Slot for the next freed register
    ptr_t tail;

    // Registers available to speculative renames
    logic [$clog2(FREE_DEPTH+1)-1:0] spec_count;

    logic pop;

    function automatic ptr_t next_ptr(input ptr_t ptr);
        ptr_t nxt;
        if (ptr == ptr_t'(FREE_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + ptr_t'(1);
        end
        return nxt;
    endfunction

    assign alloc_preg  = entries[spec_head];
    assign alloc_stall = alloc_req && (spec_count == '0);
    assign pop         = alloc_req && !alloc_stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            // Every register above the architectural set starts free
            for (int i = 0; i < FREE_DEPTH; i++) begin
                entries[i] <= PHYS_IDX_W'(ARCH_REGS + i);
            end
            spec_head    <= '0;
            retired_head <= '0;
            tail         <= '0;
            spec_count   <= ($clog2(FREE_DEPTH+1))'(FREE_DEPTH);
        end else begin
            if (retire.retire_enable) begin
                entries[tail] <= retire.retire_old_preg;
                tail          <= next_ptr(tail);
                retired_head  <= next_ptr(retired_head);
            end

            if (retire.restore_enable) begin
                // Committed state always owns a full list
                spec_head  <= retired_head;
                spec_count <= ($clog2(FREE_DEPTH+1))'(FREE_DEPTH);
            end else begin
                if (pop) begin
                    spec_head <= next_ptr(spec_head);
                end
                case ({pop, retire.retire_enable})
                    2'b10:   spec_count <= spec_count - 1'b1;
                    2'b01:   spec_count <= spec_count + 1'b1;
                    default: spec_count <= spec_count;
                endcase
            end
        end
    end

    // A retire without a matching allocation would overflow the ring
    assert property (@(posedge clk) disable iff (reset)
        spec_count <= ($clog2(FREE_DEPTH+1))'(FREE_DEPTH))
        else $error("free list count above depth");

endmodule

// ==== rtl/map_table.sv ====
// Speculative and retired rename maps with CDB ready forwarding, used inside the rename unit
`timescale 1ns/1ps

module map_table (
    input  logic                              clk,
    input  logic                              reset,

    // Source operand lookups
    input  logic [rename_pkg::ARCH_IDX_W-1:0] src1_arch,
    input  logic [rename_pkg::ARCH_IDX_W-1:0] src2_arch,
    output rename_pkg::preg_t                 src1_preg,
    output rename_pkg::preg_t                 src2_preg,

    // Destination rename
    input  logic                              rename_valid,
    input  logic [rename_pkg::ARCH_IDX_W-1:0] dest_arch,
    output logic                              alloc_req,
    input  logic [rename_pkg::PHYS_IDX_W-1:0] alloc_preg,
    input  logic                              alloc_stall,
    output rename_pkg::preg_t                 old_dest_preg,

    // Completion broadcast
    input  logic                              cdb_valid,
    input  logic [rename_pkg::PHYS_IDX_W-1:0] cdb_preg,

    // Retire and restore events
    retire_if.sink                            retire,

    // Retired map query
    input  logic [rename_pkg::ARCH_IDX_W-1:0] arch_query,
    output rename_pkg::preg_t                 arch_map_preg
);
    import rename_pkg::*;

    preg_t spec_map    [ARCH_REGS];
    preg_t retired_map [ARCH_REGS];

    // Pre-rename mapping of the destination, held for one cycle
    preg_t old_dest_q;

    logic  map_write;

    // Speculative lookup with same-cycle CDB forwarding
    function automatic preg_t lookup(input logic [ARCH_IDX_W-1:0] idx);
        preg_t entry;
        entry = spec_map[idx];
        if (idx == ZERO_REG) begin
            entry.reg_num = '0;
            entry.ready   = 1'b1;
        end else if (cdb_valid && (entry.reg_num == cdb_preg)) begin
            entry.ready = 1'b1;
        end
        return entry;
    endfunction

    // Only a real destination asks the free list for a register
    assign alloc_req = rename_valid && (dest_arch != ZERO_REG);
    assign map_write = alloc_req && !alloc_stall;

    always_comb begin
        src1_preg = lookup(src1_arch);
    end

    always_comb begin
        src2_preg = lookup(src2_arch);
    end

    // Old destination may complete while waiting in the register
    always_comb begin
        old_dest_preg = old_dest_q;
        if (cdb_valid && (old_dest_q.reg_num == cdb_preg)) begin
            old_dest_preg.ready = 1'b1;
        end
    end

    // Retired map changes only at the edge after a retire
    assign arch_map_preg = retired_map[arch_query];

    always_ff @(posedge clk) begin
        if (reset) begin
            // Identity mapping with every value present
            for (int i = 0; i < ARCH_REGS; i++) begin
                spec_map[i].reg_num    <= PHYS_IDX_W'(i);
                spec_map[i].ready      <= 1'b1;
                retired_map[i].reg_num <= PHYS_IDX_W'(i);
                retired_map[i].ready   <= 1'b1;
            end
            old_dest_q.reg_num <= '0;
            old_dest_q.ready   <= 1'b1;
        end else begin
            // Capture before the new mapping lands
            old_dest_q <= lookup(dest_arch);

            if (retire.restore_enable) begin
                // Flush beats any rename or broadcast this cycle
                for (int i = 0; i < ARCH_REGS; i++) begin
                    spec_map[i] <= retired_map[i];
                end
            end else begin
                if (cdb_valid) begin
                    for (int i = 0; i < ARCH_REGS; i++) begin
                        if (spec_map[i].reg_num == cdb_preg) begin
                            spec_map[i].ready <= 1'b1;
                        end
                    end
                end
                // New tag is not ready until it shows up on the CDB
                if (map_write) begin
                    spec_map[dest_arch].reg_num <= alloc_preg;
                    spec_map[dest_arch].ready   <= 1'b0;
                end
            end

            // Picks up a ready bit broadcast in the same cycle
            if (retire.retire_enable) begin
                retired_map[retire.retire_arch_reg] <= lookup(retire.retire_arch_reg);
            end
        end
    end

    // Flush and retire come from the ROB and must not overlap
    assert property (@(posedge clk) disable iff (reset)
        !(retire.retire_enable && retire.restore_enable))
        else $error("retire and restore in the same cycle");

    // Zero register never retires into the architectural map
    assert property (@(posedge clk) disable iff (reset)
        retire.retire_enable |-> (retire.retire_arch_reg != ZERO_REG))
        else $error("retire targets the zero register");

endmodule

// ==== rtl/retire_if.sv ====
// Retire and restore event group, driven by the rename top level and received by the map table and free list
`timescale 1ns/1ps

interface retire_if;
    import rename_pkg::*;

    // An instruction leaves the ROB this cycle
    logic                  retire_enable;
    logic [ARCH_IDX_W-1:0] retire_arch_reg;
    // Previous mapping of the retiring destination, returned to the free list
    logic [PHYS_IDX_W-1:0] retire_old_preg;

    // Flush pulse, drop all speculative state
    logic                  restore_enable;

    modport source (
        output retire_enable,
        output retire_arch_reg,
        output retire_old_preg,
        output restore_enable
    );

    modport sink (
        input retire_enable,
        input retire_arch_reg,
        input retire_old_preg,
        input restore_enable
    );

endinterface

// ==== rtl/rename_pkg.sv ====
// Shared register-count constants and the physical-register tag type, imported by the rename RTL
package rename_pkg;

    // Architectural register file size, register 0 reads as zero
    localparam int ARCH_REGS = 32;

    // Physical register file size
    localparam int PHYS_REGS = 64;

    // Index widths
    localparam int ARCH_IDX_W = $clog2(ARCH_REGS);
    localparam int PHYS_IDX_W = $clog2(PHYS_REGS);

    // Registers not held by the retired map start out free
    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;

    // Hardwired zero register
    localparam logic [ARCH_IDX_W-1:0] ZERO_REG = '0;

    // Physical register tag with its value-ready flag
    typedef struct packed {
        logic [PHYS_IDX_W-1:0] reg_num;
        logic                  ready;
    } preg_t;

endpackage
